// ==== bench/cpu16_ram.sv ====
module cpu16_ram (
    input               clk,
    input        [23:0] addr,
    input        [15:0] din,
    input        [1:0]  we,
    output logic [15:0] dout
);

timeunit 1ns;
timeprecision 100ps;

localparam int WORDS = 1024;

// filled by the testbench before each program
logic [15:0] mem [0:WORDS-1];
logic [9:0]  idx;

assign idx = addr[9:0];

// byte writes, read data one clock after the address
always @(posedge clk) begin
    if (we[0]) begin
        mem[idx][7:0] <= din[7:0];
    end
    if (we[1]) begin
        mem[idx][15:8] <= din[15:8];
    end
    dout <= mem[idx];
end

endmodule

// ==== bench/cpu16_tb.sv ====
module cpu16_tb import cpu16_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int MEM_WORDS  = 1024;
localparam int HALT_LIMIT = 2000;
localparam int DUMP_BYTES = 18;

// corner cases for carry, borrow, overflow and zero
localparam op_e         DIR_OP [6] = '{ADD, ADD, ADD, SUB, SUB, XOR_OP};
localparam logic [15:0] DIR_A  [6] = '{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0000, 16'h8000,
                                       16'h1234};
localparam logic [15:0] DIR_B  [6] = '{16'h0001, 16'h8000, 16'h0001, 16'h0001, 16'h0001,
                                       16'h1234};

logic        clk;
logic        cen;
logic        rst_n;
logic [7:0]  dmp_addr;
logic [23:0] ram_addr;
logic [15:0] ram_dout;
logic [15:0] ram_din;
logic [1:0]  ram_we;
logic [7:0]  dmp_din;
logic        halted;

// program image and the instruction-level reference model
logic [15:0] prog [$];
logic [15:0] m_mem  [0:MEM_WORDS-1];
logic [15:0] m_regs [0:7];
logic [3:0]  m_flags;

cpu16 UUT (
    .clk      ( clk      ),
    .cen      ( cen      ),
    .rst_n    ( rst_n    ),
    .ram_addr ( ram_addr ),
    .ram_dout ( ram_dout ),
    .ram_din  ( ram_din  ),
    .ram_we   ( ram_we   ),
    .dmp_addr ( dmp_addr ),
    .dmp_din  ( dmp_din  ),
    .halted   ( halted   )
);

cpu16_ram u_ram (
    .clk  ( clk      ),
    .addr ( ram_addr ),
    .din  ( ram_din  ),
    .we   ( ram_we   ),
    .dout ( ram_dout )
);

always #2 clk = ~clk;

task stop_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
endtask

task check_eq(input string name, input logic [23:0] exp, input logic [23:0] got);
    assert (got === exp)
    else stop_run($sformatf("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                            $time, name, exp, got));
endtask

a_halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted)
    else stop_run($sformatf("halted dropped without a reset at %0t ns", $time));

a_halt_no_store: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> ram_we == 2'b00)
    else check_eq("ram_we after halt", 0, $sampled(ram_we));

a_store_word: assert property (@(posedge clk) disable iff (!rst_n)
    ram_we != 2'b00 |-> ram_we == 2'b11)
    else check_eq("ram_we on store", 3, $sampled(ram_we));

a_store_range: assert property (@(posedge clk) disable iff (!rst_n)
    ram_we != 2'b00 |-> ram_addr < MEM_WORDS)
    else stop_run($sformatf("store outside the RAM model at %0t ns", $time));

task drive_cen;
    forever begin
        @(posedge clk);
        cen <= ($urandom % 4) != 0;
    end
endtask

task emit(input op_e op, input int d, input int lo);
    prog.push_back({op, 1'b0, 3'(d), 8'(lo)});
endtask

task emit_rr(input op_e op, input int d, input int s);
    emit(op, d, s * 16);
endtask

task emit_const(input int d, input logic [15:0] value);
    emit(LDI, d, value[7:0]);
    emit(LDH, d, value[15:8]);
endtask

task load_image;
    for (int i = 0; i < MEM_WORDS; i++) begin
        // spare words decode as HALT with the address in the low bits
        if (i < prog.size())
            m_mem[i] = prog[i];
        else
            m_mem[i] = 16'hC000 | 16'(i);
        u_ram.mem[i] = m_mem[i];
    end
endtask

task run_model;
    logic [23:0] pc;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    int          d;
    int          usum;
    int          ssum;
    int          steps;
    bit          done;
    bit          take;
    for (int i = 0; i < 8; i++) begin
        m_regs[i] = '0;
    end
    m_flags = 4'h0;
    pc      = '0;
    steps   = 0;
    done    = 1'b0;
    while (!done) begin
        if (steps >= 10000)
            stop_run("reference model ran 10000 steps without reaching HALT");
        w    = m_mem[pc[9:0]];
        pc   = pc + 1;
        steps++;
        d    = w[10:8];
        a    = m_regs[d];
        b    = m_regs[w[6:4]];
        r    = a;
        take = 1'b0;
        ssum = 0;
        case (w[15:12])
            LDI:    m_regs[d] = {8'h00, w[7:0]};
            LDH:    m_regs[d] = {w[7:0], a[7:0]};
            ADD: begin
                usum = a + b;
                ssum = $signed(a) + $signed(b);
                r    = usum[15:0];
                m_flags[FLAG_C] = usum > 65535;
            end
            SUB: begin
                ssum = $signed(a) - $signed(b);
                r    = a - b;
                m_flags[FLAG_C] = a < b;
            end
            AND_OP: r = a & b;
            OR_OP:  r = a | b;
            XOR_OP: r = a ^ b;
            LD:     m_regs[d] = m_mem[b[9:0]];
            ST:     m_mem[a[9:0]] = b;
            // condition code sits in the destination field
            JR:     take = d == 0 || (d == 1 && m_flags[FLAG_Z]) || (d == 2 && !m_flags[FLAG_Z]);
            DJNZ: begin
                m_regs[d] = a - 1;
                take      = a != 16'd1;
            end
            HALT:   done = 1'b1;
            default: ;
        endcase
        // logic operations have no carry
        if (w[15:12] inside {AND_OP, OR_OP, XOR_OP})
            m_flags[FLAG_C] = 1'b0;
        if (w[15:12] inside {ADD, SUB, AND_OP, OR_OP, XOR_OP}) begin
            m_regs[d]       = r;
            m_flags[FLAG_Z] = r == 16'h0000;
            m_flags[FLAG_S] = r[15];
            m_flags[FLAG_V] = ssum > 32767 || ssum < -32768;
        end
        if (take)
            pc = pc + {{16{w[7]}}, w[7:0]};
    end
endtask

function logic [7:0] model_byte(input int i);
    if (i < 16)
        return i[0] ? m_regs[i / 2][15:8] : m_regs[i / 2][7:0];
    else if (i == 16)
        return {4'h0, m_flags};
    return 8'h00;
endfunction

task apply_reset;
    int n;
    bit done;
    @(posedge clk);
    rst_n <= 1'b0;
    for (int i = 0; i < 4; i++) begin
        @(posedge clk);
        if (i == 3)
            rst_n <= 1'b1;
        @(negedge clk);
        check_eq("ram_we in reset", 0, ram_we);
        check_eq("halted in reset", 0, halted);
        check_eq("ram_addr in reset", 0, ram_addr);
    end
    // first enabled cycle out of reset
    n    = 0;
    done = 1'b0;
    while (!done) begin
        if (cen) begin
            check_eq("ram_we after reset", 0, ram_we);
            check_eq("halted after reset", 0, halted);
            check_eq("ram_addr after reset", 0, ram_addr);
            done = 1'b1;
        end else begin
            n++;
            if (n > 100)
                stop_run("cen stayed low for 100 cycles after reset");
            @(negedge clk);
        end
    end
endtask

task wait_halted(input string name);
    int n;
    n = 0;
    while (!halted) begin
        @(negedge clk);
        n++;
        if (n >= HALT_LIMIT)
            stop_run($sformatf("program %s did not halt within %0d cycles", name, HALT_LIMIT));
    end
endtask

task check_dump;
    for (int i = 0; i < DUMP_BYTES; i++) begin
        @(posedge clk);
        dmp_addr <= 8'(i);
        @(negedge clk);
        check_eq($sformatf("dmp_din byte %0d", i), model_byte(i), dmp_din);
    end
endtask

task check_memory;
    for (int i = 0; i < MEM_WORDS; i++) begin
        check_eq($sformatf("u_ram.mem[%0d]", i), m_mem[i], u_ram.mem[i]);
    end
endtask

task hold_halted;
    int b;
    for (int i = 0; i < 20; i++) begin
        // walk the dump port so every cycle sees a register byte
        b = i % 17;
        @(posedge clk);
        dmp_addr <= 8'(b);
        @(negedge clk);
        check_eq("halted", 1, halted);
        check_eq("ram_we", 0, ram_we);
        check_eq($sformatf("dmp_din byte %0d", b), model_byte(b), dmp_din);
    end
endtask

task run_program(input string name);
    @(negedge clk);
    load_image;
    run_model;
    apply_reset;
    wait_halted(name);
    check_dump;
    check_memory;
    // registers frozen while halted
    hold_halted;
    check_dump;
endtask

initial begin
    logic [15:0] a;
    logic [15:0] b;
    op_e         op;
    int          d;
    int          s;
    clk      = 1'b0;
    cen      = 1'b0;
    rst_n    = 1'b0;
    dmp_addr = 8'h00;
    void'($urandom(61593));
    fork
        drive_cen();
    join_none

    // constants in all eight registers
    prog.delete();
    for (int r = 0; r < 8; r++) begin
        emit_const(r, 16'($urandom));
    end
    emit(HALT, 0, 0);
    run_program("constants");

    // one ALU operation per program
    for (int k = 0; k < 20; k++) begin
        if (k < 6) begin
            op = DIR_OP[k];
            a  = DIR_A[k];
            b  = DIR_B[k];
            d  = 1;
            s  = 2;
        end else begin
            op = op_e'(4'(ADD + $urandom % 5));
            a  = 16'($urandom);
            b  = 16'($urandom);
            d  = $urandom % 8;
            s  = $urandom % 8;
        end
        prog.delete();
        emit_const(d, a);
        emit_const(s, b);
        emit_rr(op, d, s);
        emit(HALT, 0, 0);
        run_program($sformatf("alu %0d", k));
    end

    // store and load back, plus a load of an untouched word
    prog.delete();
    emit_const(1, 16'h0200);
    emit_const(2, 16'($urandom));
    emit_rr(ST, 1, 2);
    emit_const(4, 16'h0201);
    emit_const(5, 16'($urandom));
    emit_rr(ST, 4, 5);
    emit_rr(LD, 3, 1);
    emit_rr(LD, 6, 4);
    emit_const(7, 16'h0123);
    emit_rr(LD, 0, 7);
    emit(HALT, 0, 0);
    run_program("load store");

    // DJNZ sum loop, then jumps around a poisoned load
    prog.delete();
    emit(LDI, 0, 5);
    emit(LDI, 1, 0);
    emit_const(2, 16'($urandom));
    emit_rr(ADD, 1, 2);
    emit(DJNZ, 0, -2);
    emit(LDI, 3, 8'h5A);
    emit_rr(OR_OP, 3, 3);
    emit(JR, 1, 1);
    emit(JR, 0, 1);
    emit(LDI, 3, 8'hEE);
    emit(HALT, 0, 0);
    run_program("loop and jumps");

    $display("STATUS: PASS");
    $finish;
end

endmodule

// ==== cpu16.f ====
rtl/cpu16_pkg.sv
rtl/cpu16_alu.sv
rtl/cpu16_ctrl.sv
rtl/cpu16_pc.sv
rtl/cpu16_ramctl.sv
rtl/cpu16_regs.sv
rtl/cpu16.sv
bench/cpu16_ram.sv
bench/cpu16_tb.sv

// ==== rtl/cpu16.sv ====
module cpu16 import cpu16_pkg::*; (
    input                clk,
    input                cen,
    input                rst_n,

    output  [ADDR_W-1:0] ram_addr,
    input   [DATA_W-1:0] ram_dout,
    output  [DATA_W-1:0] ram_din,
    output  [1:0]        ram_we,
    // register dump
    input   [7:0]        dmp_addr,
    output  [7:0]        dmp_din,

    output               halted
);

// control
logic [REG_SEL_W-1:0] reg_dst, reg_src;
logic                 reg_we, wr_sel_mem, flag_we;
alu_op_e              alu_op;
logic [7:0]           imm;

// register bank and ALU
logic [DATA_W-1:0]    dst_out, src_out, alu_dout;
logic [3:0]           flags, nx_flags;
logic                 dec_zero;

// program counter and memory
logic [ADDR_W-1:0]    pc;
logic                 pc_inc, pc_rel;
logic                 fetch_req, data_rd, data_wr;
logic [DATA_W-1:0]    ram_data;
logic                 instr_ok, ram_rdy;

cpu16_ctrl u_ctrl(
    .clk        ( clk        ),
    .cen        ( cen        ),
    .rst_n      ( rst_n      ),
    .instr      ( ram_data   ),
    .instr_ok   ( instr_ok   ),
    .ram_rdy    ( ram_rdy    ),
    .flags      ( flags      ),
    .dec_zero   ( dec_zero   ),
    .reg_dst    ( reg_dst    ),
    .reg_src    ( reg_src    ),
    .reg_we     ( reg_we     ),
    .wr_sel_mem ( wr_sel_mem ),
    .alu_op     ( alu_op     ),
    .imm        ( imm        ),
    .flag_we    ( flag_we    ),
    .pc_inc     ( pc_inc     ),
    .pc_rel     ( pc_rel     ),
    .fetch_req  ( fetch_req  ),
    .data_rd    ( data_rd    ),
    .data_wr    ( data_wr    ),
    .halted     ( halted     )
);

cpu16_regs u_regs(
    .clk        ( clk        ),
    .cen        ( cen        ),
    .rst_n      ( rst_n      ),
    .reg_dst    ( reg_dst    ),
    .reg_src    ( reg_src    ),
    .reg_we     ( reg_we     ),
    .wr_sel_mem ( wr_sel_mem ),
    .alu_dout   ( alu_dout   ),
    .ram_data   ( ram_data   ),
    .flag_we    ( flag_we    ),
    .nx_flags   ( nx_flags   ),
    .dmp_addr   ( dmp_addr   ),
    .dst_out    ( dst_out    ),
    .src_out    ( src_out    ),
    .flags      ( flags      ),
    .dmp_din    ( dmp_din    )
);

cpu16_alu u_alu(
    .dst_in     ( dst_out    ),
    .src_in     ( src_out    ),
    .imm        ( imm        ),
    .alu_op     ( alu_op     ),
    .flags_in   ( flags      ),
    .alu_dout   ( alu_dout   ),
    .nx_flags   ( nx_flags   ),
    .dec_zero   ( dec_zero   )
);

// jump offset shares the immediate field
cpu16_pc u_pc(
    .clk        ( clk        ),
    .cen        ( cen        ),
    .rst_n      ( rst_n      ),
    .pc_inc     ( pc_inc     ),
    .pc_rel     ( pc_rel     ),
    .offset     ( imm        ),
    .pc         ( pc         )
);

cpu16_ramctl u_ramctl(
    .clk        ( clk        ),
    .cen        ( cen        ),
    .rst_n      ( rst_n      ),
    .pc         ( pc         ),
    .fetch_req  ( fetch_req  ),
    .data_rd    ( data_rd    ),
    .data_wr    ( data_wr    ),
    .rd_addr    ( src_out    ),
    .wr_addr    ( dst_out    ),
    .wr_data    ( src_out    ),
    .ram_dout   ( ram_dout   ),
    .ram_addr   ( ram_addr   ),
    .ram_din    ( ram_din    ),
    .ram_we     ( ram_we     ),
    .ram_data   ( ram_data   ),
    .instr_ok   ( instr_ok   ),
    .ram_rdy    ( ram_rdy    )
);

endmodule

// ==== rtl/cpu16_alu.sv ====
module cpu16_alu import cpu16_pkg::*; (
    input        [DATA_W-1:0] dst_in,
    input        [DATA_W-1:0] src_in,
    input        [7:0]        imm,
    input  alu_op_e           alu_op,
    input        [3:0]        flags_in,

    output logic [DATA_W-1:0] alu_dout,
    output logic [3:0]        nx_flags,
    output                    dec_zero
);

logic [DATA_W:0]   sum;
logic [DATA_W:0]   diff;
logic [DATA_W-1:0] dec_val;
logic              add_v;
logic              sub_v;
logic              upd_zs;

// extra bit carries out of the top, and for SUB it is the borrow
assign sum  = {1'b0, dst_in} + {1'b0, src_in};
assign diff = {1'b0, dst_in} - {1'b0, src_in};

assign add_v = (dst_in[15] == src_in[15]) && (sum[15] != dst_in[15]);
assign sub_v = (dst_in[15] != src_in[15]) && (diff[15] != dst_in[15]);

// DJNZ test works on the decremented value
assign dec_val  = dst_in - 16'd1;
assign dec_zero = dec_val == '0;

always_comb begin
    alu_dout = dst_in;
    nx_flags = flags_in;
    upd_zs   = 1'b1;
    case (alu_op)
        ALU_PASS_IMM_LO: begin
            alu_dout = {8'h00, imm};
            upd_zs   = 1'b0;
        end
        ALU_PASS_IMM_HI: begin
            alu_dout = {imm, dst_in[7:0]};
            upd_zs   = 1'b0;
        end
        ALU_ADD: begin
            alu_dout         = sum[DATA_W-1:0];
            nx_flags[FLAG_C] = sum[DATA_W];
            nx_flags[FLAG_V] = add_v;
        end
        ALU_SUB: begin
            alu_dout         = diff[DATA_W-1:0];
            nx_flags[FLAG_C] = diff[DATA_W];
            nx_flags[FLAG_V] = sub_v;
        end
        ALU_AND: alu_dout = dst_in & src_in;
        ALU_OR:  alu_dout = dst_in | src_in;
        ALU_XOR: alu_dout = dst_in ^ src_in;
        default: begin
            // decrement keeps the flags as they are
            alu_dout = dec_val;
            upd_zs   = 1'b0;
        end
    endcase
    if (alu_op inside {ALU_AND, ALU_OR, ALU_XOR}) begin
        nx_flags[FLAG_C] = 1'b0;
        nx_flags[FLAG_V] = 1'b0;
    end
    if (upd_zs) begin
        nx_flags[FLAG_Z] = alu_dout == '0;
        nx_flags[FLAG_S] = alu_dout[15];
    end
end

endmodule

// ==== rtl/cpu16_ctrl.sv ====
module cpu16_ctrl import cpu16_pkg::*; (
    input                        clk,
    input                        cen,
    input                        rst_n,

    input        [DATA_W-1:0]    instr,
    input                        instr_ok,
    input                        ram_rdy,
    input        [3:0]           flags,
    input                        dec_zero,

    output       [REG_SEL_W-1:0] reg_dst,
    output       [REG_SEL_W-1:0] reg_src,
    output logic                 reg_we,
    output logic                 wr_sel_mem,
    output alu_op_e              alu_op,
    output       [7:0]           imm,
    output logic                 flag_we,
    output logic                 pc_inc,
    output logic                 pc_rel,
    output logic                 fetch_req,
    output logic                 data_rd,
    output logic                 data_wr,
    output                       halted
);

ctrl_state_e       state;
logic [DATA_W-1:0] ir;
op_e               op;
logic              jr_taken;

// instruction fields
assign op      = op_e'(ir[15:12]);
assign reg_dst = ir[10:8];
assign reg_src = ir[6:4];
assign imm     = ir[7:0];
assign halted  = state == HALTED;

// JR condition lives in the destination field
always_comb begin
    case (ir[10:8])
        3'd0:    jr_taken = 1'b1;
        3'd1:    jr_taken = flags[FLAG_Z];
        3'd2:    jr_taken = !flags[FLAG_Z];
        default: jr_taken = 1'b0;
    endcase
end

always_comb begin
    reg_we     = 1'b0;
    wr_sel_mem = 1'b0;
    flag_we    = 1'b0;
    alu_op     = ALU_PASS_IMM_LO;
    pc_inc     = 1'b0;
    pc_rel     = 1'b0;
    fetch_req  = 1'b0;
    data_rd    = 1'b0;
    data_wr    = 1'b0;
    case (state)
        FETCH: begin
            // pc moves past the word as it is requested
            pc_inc    = 1'b1;
            fetch_req = cen;
        end
        EXEC: begin
            case (op)
                LDI: begin
                    reg_we = 1'b1;
                end
                LDH: begin
                    reg_we = 1'b1;
                    alu_op = ALU_PASS_IMM_HI;
                end
                ADD: begin
                    reg_we  = 1'b1;
                    flag_we = 1'b1;
                    alu_op  = ALU_ADD;
                end
                SUB: begin
                    reg_we  = 1'b1;
                    flag_we = 1'b1;
                    alu_op  = ALU_SUB;
                end
                AND_OP: begin
                    reg_we  = 1'b1;
                    flag_we = 1'b1;
                    alu_op  = ALU_AND;
                end
                OR_OP: begin
                    reg_we  = 1'b1;
                    flag_we = 1'b1;
                    alu_op  = ALU_OR;
                end
                XOR_OP: begin
                    reg_we  = 1'b1;
                    flag_we = 1'b1;
                    alu_op  = ALU_XOR;
                end
                LD:   data_rd = cen;
                ST:   data_wr = cen;
                JR:   pc_rel  = jr_taken;
                DJNZ: begin
                    // counter written back, jump unless it reached zero
                    reg_we = 1'b1;
                    alu_op = ALU_DEC;
                    pc_rel = !dec_zero;
                end
                default: ;
            endcase
        end
        WRITE: begin
            reg_we     = 1'b1;
            wr_sel_mem = 1'b1;
        end
        default: ;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state <= FETCH;
    end else if (cen) begin
        case (state)
            FETCH:    state <= OP_WAIT;
            OP_WAIT:  if (instr_ok) state <= EXEC;
            EXEC: begin
                case (op)
                    LD:      state <= MEM_WAIT;
                    HALT:    state <= HALTED;
                    default: state <= FETCH;
                endcase
            end
            MEM_WAIT: if (ram_rdy) state <= WRITE;
            WRITE:    state <= FETCH;
            HALTED:   state <= HALTED;
            default:  state <= FETCH;
        endcase
    end
end

// instruction register
always_ff @(posedge clk) begin
    if (cen && state == OP_WAIT && instr_ok) begin
        ir <= instr;
    end
end

a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(data_rd && data_wr))
    else $error("data_rd and data_wr asserted together");

// once halted the register bank must stay frozen
a_halt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> halted && !reg_we)
    else $error("register write or exit after HALT");

endmodule

// ==== rtl/cpu16_pc.sv ====
module cpu16_pc import cpu16_pkg::*; (
    input                     clk,
    input                     cen,
    input                     rst_n,

    input                     pc_inc,
    input                     pc_rel,
    input        [7:0]        offset,

    output logic [ADDR_W-1:0] pc
);

logic [ADDR_W-1:0] rel_step;

// signed jump offset
assign rel_step = {{(ADDR_W-8){offset[7]}}, offset};

always_ff @(posedge clk) begin
    if (!rst_n) begin
        pc <= '0;
    end else if (cen) begin
        if (pc_inc) begin
            pc <= pc + 1'b1;
        end else if (pc_rel) begin
            pc <= pc + rel_step;
        end
    end
end

a_inc_rel_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(pc_inc && pc_rel))
    else $error("pc_inc and pc_rel asserted together");

endmodule

// ==== rtl/cpu16_pkg.sv ====
package cpu16_pkg;

    // word widths fixed by the instruction set
    localparam int ADDR_W    = 24;
    localparam int DATA_W    = 16;
    localparam int REG_SEL_W = 3;

    // positions inside the 4-bit flag word
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_S = 2;
    localparam int FLAG_V = 3;

    // instruction opcodes, bits 15:12 of the word
    typedef enum logic [3:0] {
        NOP    = 4'd0,
        LDI    = 4'd1,
        LDH    = 4'd2,
        ADD    = 4'd3,
        SUB    = 4'd4,
        AND_OP = 4'd5,
        OR_OP  = 4'd6,
        XOR_OP = 4'd7,
        LD     = 4'd8,
        ST     = 4'd9,
        JR     = 4'd10,
        DJNZ   = 4'd11,
        HALT   = 4'd12
    } op_e;

    // ALU operations, prefixed to keep them apart from the opcodes
    typedef enum logic [2:0] {
        ALU_PASS_IMM_LO = 3'd0,
        ALU_PASS_IMM_HI = 3'd1,
        ALU_ADD         = 3'd2,
        ALU_SUB         = 3'd3,
        ALU_AND         = 3'd4,
        ALU_OR          = 3'd5,
        ALU_XOR         = 3'd6,
        ALU_DEC         = 3'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        FETCH    = 3'd0,
        OP_WAIT  = 3'd1,
        EXEC     = 3'd2,
        MEM_WAIT = 3'd3,
        WRITE    = 3'd4,
        HALTED   = 3'd5
    } ctrl_state_e;

endpackage

// ==== rtl/cpu16_ramctl.sv ====
module cpu16_ramctl import cpu16_pkg::*; (
    input                     clk,
    input                     cen,
    input                     rst_n,

    input        [ADDR_W-1:0] pc,
    input                     fetch_req,
    input                     data_rd,
    input                     data_wr,
    input        [DATA_W-1:0] rd_addr,
    input        [DATA_W-1:0] wr_addr,
    input        [DATA_W-1:0] wr_data,
    // RAM interface
    input        [DATA_W-1:0] ram_dout,
    output logic [ADDR_W-1:0] ram_addr,
    output       [DATA_W-1:0] ram_din,
    output       [1:0]        ram_we,

    output       [DATA_W-1:0] ram_data,
    output                    instr_ok,
    output                    ram_rdy
);

logic [ADDR_W-1:0] addr_q;
logic [DATA_W-1:0] data_q;
logic              pending;
logic              pend_fetch;
logic              req;

assign req = fetch_req || data_rd || data_wr;

// address held between requests so the RAM sees a stable word
always_comb begin
    if (fetch_req) begin
        ram_addr = pc;
    end else if (data_rd) begin
        ram_addr = {{(ADDR_W-DATA_W){1'b0}}, rd_addr};
    end else if (data_wr) begin
        ram_addr = {{(ADDR_W-DATA_W){1'b0}}, wr_addr};
    end else begin
        ram_addr = addr_q;
    end
end

assign ram_din  = wr_data;
assign ram_we   = data_wr ? 2'b11 : 2'b00;
assign instr_ok = pending && pend_fetch;
assign ram_rdy  = pending && !pend_fetch;
// last read word kept for the load write-back
assign ram_data = pending ? ram_dout : data_q;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        addr_q     <= '0;
        pending    <= 1'b0;
        pend_fetch <= 1'b0;
    end else if (cen) begin
        if (req) begin
            addr_q <= ram_addr;
        end
        pending    <= fetch_req || data_rd;
        pend_fetch <= fetch_req;
    end
end

always_ff @(posedge clk) begin
    if (cen && pending) begin
        data_q <= ram_dout;
    end
end

a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    pending |-> !req)
    else $error("RAM request while a read is pending");

endmodule

// ==== rtl/cpu16_regs.sv ====
module cpu16_regs import cpu16_pkg::*; (
    input                        clk,
    input                        cen,
    input                        rst_n,

    input        [REG_SEL_W-1:0] reg_dst,
    input        [REG_SEL_W-1:0] reg_src,
    input                        reg_we,
    input                        wr_sel_mem,
    input        [DATA_W-1:0]    alu_dout,
    input        [DATA_W-1:0]    ram_data,
    input                        flag_we,
    input        [3:0]           nx_flags,
    // register dump
    input        [7:0]           dmp_addr,

    output       [DATA_W-1:0]    dst_out,
    output       [DATA_W-1:0]    src_out,
    output logic [3:0]           flags,
    output logic [7:0]           dmp_din
);

// dump byte that holds the flags
localparam logic [7:0] DMP_FLAGS = 8'd16;

logic [DATA_W-1:0] regs [0:7];
logic [DATA_W-1:0] wr_data;
logic [DATA_W-1:0] dmp_word;

assign dst_out = regs[reg_dst];
assign src_out = regs[reg_src];
assign wr_data = wr_sel_mem ? ram_data : alu_dout;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
        end
        flags <= 4'h0;
    end else if (cen) begin
        if (reg_we) begin
            regs[reg_dst] <= wr_data;
        end
        if (flag_we) begin
            flags <= nx_flags;
        end
    end
end

// register n sits at bytes 2n and 2n+1
assign dmp_word = regs[dmp_addr[3:1]];

always_comb begin
    if (dmp_addr < DMP_FLAGS) begin
        dmp_din = dmp_addr[0] ? dmp_word[15:8] : dmp_word[7:0];
    end else if (dmp_addr == DMP_FLAGS) begin
        dmp_din = {4'h0, flags};
    end else begin
        dmp_din = 8'h00;
    end
end

endmodule
